// ==== sim/ecc_golden.txt ====
// Columns, all hex: op (0 idle, 1 write, 2 read), addr, data, byte enables,
// inject mask, expected read data, expected flags (bit 0 single, bit 1 double)
// Idle lines: data column is the cycle count, expected data the minimum scrub fixes
1 0 12345678 f 0000000000 00000000 0
1 1 a5a5a5a5 f 0000000000 00000000 0
1 2 deadbeef f 0000000000 00000000 0
1 3 0f0f0f0f f 0000000000 00000000 0
2 0 00000000 0 0000000000 12345678 0
1 1 11223344 5 0000000000 00000000 0
1 2 00000000 a 0000000000 00000000 0
1 4 cafef00d f 0000100000 00000000 0
1 5 01234567 f 4000000000 00000000 0
2 1 00000000 0 0000000000 a522a544 0
2 2 00000000 0 0000000000 00ad00ef 0
1 6 89abcdef f 0000100008 00000000 0
2 4 00000000 0 0000000000 cafef00d 1
2 5 00000000 0 0000000000 01234567 1
1 7 55aa55aa f 0800000000 00000000 0
1 4 00000077 1 0000000000 00000000 0
2 6 00000000 0 0000000000 89bbcde7 2
2 3 00000000 0 0000000000 0f0f0f0f 0
2 7 00000000 0 0000000000 55aa55aa 1
2 4 00000000 0 0000000000 cafef077 0
1 8 13579bdf f 0080000000 00000000 0
0 0 00000064 0 0000000000 00000001 0
2 8 00000000 0 0000000000 13579bdf 0
2 5 00000000 0 0000000000 01234567 0
2 7 00000000 0 0000000000 55aa55aa 0
2 6 00000000 0 0000000000 89bbcde7 2
2 4 00000000 0 0000000000 cafef077 0

// ==== verilog.f ====
src/ecc_mem_pkg.sv
src/ecc_mem_array.sv
src/mem_arbiter.sv
src/ecc_dec.sv
src/ecc_merge_enc.sv
src/ecc_scrubber.sv
src/ecc_mem_top.sv
sim/ecc_merge_enc_properties.sv
sim/tb_ecc_mem.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; the exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert --top-module tb_ecc_mem -f verilog.f -o tb_ecc_mem &&
  ./obj_dir/tb_ecc_mem +verilator+error+limit+10 ||
  { echo "Simulation did not pass"; exit 1; }

// ==== sim/tb_ecc_mem.sv ====
// Testbench for the ECC memory. Replays the golden operation file, checks each
// read response two cycles after its strobe and bounds the run with a watchdog.
`timescale 1ns/10ps

module tb_ecc_mem
  import ecc_mem_pkg::*;
();

  localparam int         ADDR_W    = 4;
  localparam int         FIELDS    = 7;
  localparam int         MAX_LINES = 64;
  localparam logic [3:0] OP_IDLE   = 4'h0;
  localparam logic [3:0] OP_WRITE  = 4'h1;
  localparam logic [3:0] OP_READ   = 4'h2;

  logic                 clk;
  logic                 reset;
  logic                 req_valid;
  logic                 req_write;
  logic [ADDR_W-1:0]    req_addr;
  logic [DATA_W-1:0]    req_wdata;
  logic [BE_W-1:0]      req_be;
  logic [CODE_W-1:0]    req_inject;
  logic                 rsp_valid;
  logic [DATA_W-1:0]    rsp_data;
  logic                 rsp_single_err;
  logic                 rsp_double_err;
  logic [FIX_CNT_W-1:0] scrub_fixed_count;

  logic [63:0] golden [FIELDS*MAX_LINES];
  int          num_lines;
  int          idle_total;
  logic        budget_ready = 1'b0;

  // Expected responses in flight, index 1 is due at this falling edge
  logic [3:0]        stage_op    [2];
  logic [DATA_W-1:0] stage_data  [2];
  logic [1:0]        stage_flags [2];
  string             stage_name  [2];

  ecc_mem_top u_ecc_mem_top (
    .clk               (clk),
    .reset             (reset),
    .req_valid         (req_valid),
    .req_write         (req_write),
    .req_addr          (req_addr),
    .req_wdata         (req_wdata),
    .req_be            (req_be),
    .req_inject        (req_inject),
    .rsp_valid         (rsp_valid),
    .rsp_data          (rsp_data),
    .rsp_single_err    (rsp_single_err),
    .rsp_double_err    (rsp_double_err),
    .scrub_fixed_count (scrub_fixed_count)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1, "simulation stopped on error");
  endtask

  task automatic check_value(input string name, input string what,
                             input logic [31:0] expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      stop_with_error($sformatf("** Error: %s %s expected %h actual %h",
                                name, what, expected, actual));
    end
  endtask

  task automatic load_golden();
    for (int i = 0; i < FIELDS * MAX_LINES; i++) begin
      golden[i] = '1;
    end
    $readmemh("sim/ecc_golden.txt", golden);
    num_lines  = 0;
    idle_total = 0;
    // Unfilled entries keep the all-ones opcode and end the list
    while (num_lines < MAX_LINES && golden[num_lines*FIELDS][3:0] <= OP_READ) begin
      if (golden[num_lines*FIELDS][3:0] == OP_IDLE) begin
        idle_total += int'(golden[num_lines*FIELDS+2][31:0]);
      end
      num_lines++;
    end
    assert (num_lines > 0) else begin
      stop_with_error("The golden file sim/ecc_golden.txt holds no operations");
    end
  endtask

  task automatic drive_idle();
    req_valid  = 1'b0;
    req_write  = 1'b0;
    req_addr   = '0;
    req_wdata  = '0;
    req_be     = '0;
    req_inject = '0;
  endtask

  task automatic drive_line(input int line);
    int base;
    base       = line * FIELDS;
    req_valid  = 1'b1;
    req_write  = (golden[base][3:0] == OP_WRITE);
    req_addr   = golden[base+1][ADDR_W-1:0];
    req_wdata  = golden[base+2][DATA_W-1:0];
    req_be     = golden[base+3][BE_W-1:0];
    req_inject = golden[base+4][CODE_W-1:0];
    stage_op[0]    = golden[base][3:0];
    stage_data[0]  = golden[base+5][DATA_W-1:0];
    stage_flags[0] = golden[base+6][1:0];
    stage_name[0]  = $sformatf("%s_line%0d_addr%0h", req_write ? "write" : "read",
                               line + 1, req_addr);
  endtask

  // Advance to the next falling edge and check whatever response is due
  task automatic next_cycle();
    @(negedge clk);
    assert (u_ecc_mem_top.u_merge_enc.u_merge_enc_props.fail_count == 0) else begin
      stop_with_error("A bound assertion on the merge encoder failed");
    end
    if (stage_op[1] == OP_READ) begin
      check_value(stage_name[1], "rsp_valid", 32'd1, 32'(rsp_valid));
      check_value(stage_name[1], "rsp_data", stage_data[1], rsp_data);
      check_value(stage_name[1], "flags {double,single}", 32'(stage_flags[1]),
                  32'({rsp_double_err, rsp_single_err}));
    end else if (stage_op[1] == OP_IDLE) begin
      check_value("idle_slot", "rsp_valid", 32'd0, 32'(rsp_valid));
    end
    stage_op[1]    = stage_op[0];
    stage_data[1]  = stage_data[0];
    stage_flags[1] = stage_flags[0];
    stage_name[1]  = stage_name[0];
    stage_op[0]    = OP_IDLE;
  endtask

  initial begin
    int                   line;
    int                   base;
    int                   cycles;
    logic [FIX_CNT_W-1:0] count_start;
    logic [FIX_CNT_W-1:0] min_growth;
    logic [FIX_CNT_W-1:0] growth;
    reset = 1'b1;
    drive_idle();
    for (int i = 0; i < 2; i++) begin
      stage_op[i]    = OP_IDLE;
      stage_data[i]  = '0;
      stage_flags[i] = '0;
      stage_name[i]  = "none";
    end
    load_golden();
    budget_ready = 1'b1;
    repeat (4) @(negedge clk);
    reset = 1'b0;
    for (line = 0; line < num_lines; line++) begin
      base = line * FIELDS;
      if (golden[base][3:0] == OP_IDLE) begin
        drive_idle();
        count_start = scrub_fixed_count;
        cycles      = int'(golden[base+2][31:0]);
        min_growth  = golden[base+5][FIX_CNT_W-1:0];
        repeat (cycles) next_cycle();
        growth = scrub_fixed_count - count_start;
        assert (growth >= min_growth) else begin
          stop_with_error($sformatf("** Error: idle_line%0d scrub fixes expected >= %0d actual %0d",
                                    line + 1, min_growth, growth));
        end
      end else begin
        drive_line(line);
        next_cycle();
      end
    end
    // Let the last two reads come back
    drive_idle();
    repeat (2) next_cycle();
    $display("TEST PASS");
    $finish;
  end

  // Budget of 8 cycles per golden line plus every idle cycle and the reset
  initial begin
    int budget;
    wait (budget_ready);
    budget = 8 * num_lines + idle_total + 4;
    repeat (budget) @(posedge clk);
    stop_with_error($sformatf("Watchdog expired after %0d cycles, the run hung", budget));
  end

endmodule

// ==== sim/ecc_merge_enc_properties.sv ====
// Concurrent checks on the merge encoder write stage, attached with bind.
// Failures raise $error and bump fail_count for the testbench to see.
`timescale 1ns/10ps

module ecc_merge_enc_properties
  import ecc_mem_pkg::*;
(
  input logic              clk,
  input logic              reset,
  input logic              req_valid,
  input logic              req_write,
  input logic [DATA_W-1:0] req_wdata,
  input logic [BE_W-1:0]   req_be,
  input logic [CODE_W-1:0] req_inject,
  input logic [DATA_W-1:0] dec_data,
  input logic              dec_double_err,
  input logic              wr_valid,
  input ecc_word_u         wr_word
);

  int fail_count = 0;

  // Byte enables widened to one bit per data bit
  function automatic logic [DATA_W-1:0] byte_mask(input logic [BE_W-1:0] be);
    logic [DATA_W-1:0] mask;
    for (int i = 0; i < BE_W; i++) begin
      mask[i*8 +: 8] = {8{be[i]}};
    end
    return mask;
  endfunction

  // XOR of the Hamming positions of all set bits, zero for a clean code word.
  // Check bits sit at the power-of-two positions, data bits fill the rest.
  function automatic logic [ECC_W-2:0] position_xor(input ecc_word_u word);
    logic [ECC_W-2:0] acc;
    int unsigned      c;
    int unsigned      d;
    acc = '0;
    c   = 0;
    d   = 0;
    for (int unsigned pos = 1; pos < CODE_W; pos++) begin
      if ((pos & (pos - 1)) == 0) begin
        if (word.fld.ecc[c]) begin
          acc = acc ^ pos[ECC_W-2:0];
        end
        c++;
      end else begin
        if (word.fld.data[d]) begin
          acc = acc ^ pos[ECC_W-2:0];
        end
        d++;
      end
    end
    return acc;
  endfunction

  a_wr_latency: assert property (@(posedge clk) disable iff (reset)
    req_valid && req_write |-> ##2 wr_valid)
    else begin
      fail_count++;
      $error("wr_valid missing two cycles after a host write");
    end

  a_wr_origin: assert property (@(posedge clk) disable iff (reset)
    wr_valid |-> $past(req_valid && req_write, 2))
    else begin
      fail_count++;
      $error("wr_valid without a host write two cycles earlier");
    end

  a_new_bytes: assert property (@(posedge clk) disable iff (reset)
    wr_valid && ($past(req_inject, 2) == '0) |->
      ((wr_word.fld.data ^ $past(req_wdata, 2)) & byte_mask($past(req_be, 2))) == '0)
    else begin
      fail_count++;
      $error("enabled bytes differ from the request data");
    end

  a_old_bytes: assert property (@(posedge clk) disable iff (reset)
    wr_valid && ($past(req_inject, 2) == '0) && !$past(dec_double_err) |->
      ((wr_word.fld.data ^ $past(dec_data)) & ~byte_mask($past(req_be, 2))) == '0)
    else begin
      fail_count++;
      $error("kept bytes differ from the decoded old word");
    end

  a_check_bits: assert property (@(posedge clk) disable iff (reset)
    wr_valid && ($past(req_inject, 2) == '0) |->
      (position_xor(wr_word) == '0) && !(^wr_word.raw))
    else begin
      fail_count++;
      $error("check bits do not match the written data");
    end

endmodule

bind ecc_merge_enc ecc_merge_enc_properties u_merge_enc_props (
  .clk            (clk),
  .reset          (reset),
  .req_valid      (req_valid),
  .req_write      (req_write),
  .req_wdata      (req_wdata),
  .req_be         (req_be),
  .req_inject     (req_inject),
  .dec_data       (dec_data),
  .dec_double_err (dec_double_err),
  .wr_valid       (wr_valid),
  .wr_word        (wr_word)
);

// ==== src/ecc_mem_top.sv ====
// ECC word memory with read-modify-write partial writes and a scrubber.
// Host requests are single-cycle strobes; responses follow 2 cycles later.
`timescale 1ns/10ps

module ecc_mem_top
  import ecc_mem_pkg::*;
#(
  parameter int ADDR_W    = 4,
  parameter int SCRUB_GAP = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 req_valid,
  input  logic                 req_write,
  input  logic [ADDR_W-1:0]    req_addr,
  input  logic [DATA_W-1:0]    req_wdata,
  input  logic [BE_W-1:0]      req_be,
  input  logic [CODE_W-1:0]    req_inject,
  output logic                 rsp_valid,
  output logic [DATA_W-1:0]    rsp_data,
  output logic                 rsp_single_err,
  output logic                 rsp_double_err,
  output logic [FIX_CNT_W-1:0] scrub_fixed_count
);

  logic              rd_en;
  logic [ADDR_W-1:0] rd_addr;
  ecc_word_u         rd_word;
  logic              rd_owner_host;
  logic              wr_en;
  logic [ADDR_W-1:0] wr_addr;
  ecc_word_u         wr_word;

  logic [DATA_W-1:0] dec_data;
  logic              dec_single_err;
  logic              dec_double_err;

  logic              host_wr_valid;
  logic [ADDR_W-1:0] host_wr_addr;
  ecc_word_u         host_wr_word;

  logic              scrub_rd_req;
  logic [ADDR_W-1:0] scrub_rd_addr;
  logic              scrub_rd_grant;
  logic              scrub_wr_req;
  logic [ADDR_W-1:0] scrub_wr_addr;
  ecc_word_u         scrub_wr_word;
  logic              scrub_wr_grant;

  ecc_mem_array #(.ADDR_W(ADDR_W)) u_array (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_word (wr_word),
    .rd_word (rd_word)
  );

  mem_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
    .clk            (clk),
    .reset          (reset),
    .host_rd_req    (req_valid),
    .host_rd_addr   (req_addr),
    .scrub_rd_req   (scrub_rd_req),
    .scrub_rd_addr  (scrub_rd_addr),
    .host_wr_req    (host_wr_valid),
    .host_wr_addr   (host_wr_addr),
    .host_wr_word   (host_wr_word),
    .scrub_wr_req   (scrub_wr_req),
    .scrub_wr_addr  (scrub_wr_addr),
    .scrub_wr_word  (scrub_wr_word),
    .rd_en          (rd_en),
    .rd_addr        (rd_addr),
    .rd_owner_host  (rd_owner_host),
    .scrub_rd_grant (scrub_rd_grant),
    .wr_en          (wr_en),
    .wr_addr        (wr_addr),
    .wr_word        (wr_word),
    .scrub_wr_grant (scrub_wr_grant)
  );

  ecc_dec u_dec (
    .clk            (clk),
    .reset          (reset),
    .rd_word        (rd_word),
    .rd_owner_host  (rd_owner_host),
    .dec_data       (dec_data),
    .dec_single_err (dec_single_err),
    .dec_double_err (dec_double_err),
    .rsp_valid      (rsp_valid),
    .rsp_data       (rsp_data),
    .rsp_single_err (rsp_single_err),
    .rsp_double_err (rsp_double_err)
  );

  ecc_merge_enc #(.ADDR_W(ADDR_W)) u_merge_enc (
    .clk            (clk),
    .reset          (reset),
    .req_valid      (req_valid),
    .req_write      (req_write),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_be         (req_be),
    .req_inject     (req_inject),
    .dec_data       (dec_data),
    .dec_double_err (dec_double_err),
    .rd_raw_data    (rd_word.fld.data),
    .wr_valid       (host_wr_valid),
    .wr_addr        (host_wr_addr),
    .wr_word        (host_wr_word)
  );

  ecc_scrubber #(.ADDR_W(ADDR_W), .SCRUB_GAP(SCRUB_GAP)) u_scrubber (
    .clk            (clk),
    .reset          (reset),
    .rd_grant       (scrub_rd_grant),
    .rd_owner_host  (rd_owner_host),
    .dec_data       (dec_data),
    .dec_single_err (dec_single_err),
    .wr_grant       (scrub_wr_grant),
    .host_wr_valid  (host_wr_valid),
    .host_wr_addr   (host_wr_addr),
    .rd_req         (scrub_rd_req),
    .rd_addr        (scrub_rd_addr),
    .wr_req         (scrub_wr_req),
    .wr_addr        (scrub_wr_addr),
    .wr_word        (scrub_wr_word),
    .fixed_count    (scrub_fixed_count)
  );

endmodule

// ==== src/ecc_scrubber.sv ====
// Background scrubber: reads one address per paced idle slot and
// writes back any word that decoded with a correctable error.
`timescale 1ns/10ps

module ecc_scrubber
  import ecc_mem_pkg::*;
#(
  parameter int ADDR_W    = 4,
  parameter int SCRUB_GAP = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 rd_grant,
  input  logic                 rd_owner_host,
  input  logic [DATA_W-1:0]    dec_data,
  input  logic                 dec_single_err,
  input  logic                 wr_grant,
  input  logic                 host_wr_valid,
  input  logic [ADDR_W-1:0]    host_wr_addr,
  output logic                 rd_req,
  output logic [ADDR_W-1:0]    rd_addr,
  output logic                 wr_req,
  output logic [ADDR_W-1:0]    wr_addr,
  output ecc_word_u            wr_word,
  output logic [FIX_CNT_W-1:0] fixed_count
);

  localparam int GAP_W = (SCRUB_GAP > 0) ? $clog2(SCRUB_GAP + 1) : 1;

  logic [GAP_W-1:0]  gap_cnt;
  logic              rd_pend;
  logic              rd_stale;
  logic [ADDR_W-1:0] pend_addr;
  logic              capture;
  logic              host_hit_pend;
  ecc_word_u         fix_word;

  assign rd_req        = (gap_cnt == '0) & ~rd_pend & ~wr_req;
  assign capture       = rd_pend & ~rd_owner_host;
  assign host_hit_pend = host_wr_valid & (host_wr_addr == pend_addr);

  assign fix_word.fld.data = dec_data;
  assign fix_word.fld.ecc  = ecc_encode(dec_data);

  always_ff @(posedge clk) begin
    if (reset) begin
      gap_cnt     <= '0;
      rd_addr     <= '0;
      rd_pend     <= 1'b0;
      rd_stale    <= 1'b0;
      wr_req      <= 1'b0;
      fixed_count <= '0;
    end else begin
      rd_pend <= rd_grant;
      if (rd_grant) begin
        gap_cnt  <= GAP_W'(SCRUB_GAP);
        rd_addr  <= rd_addr + 1'b1;
        // A host write landing now leaves the scrub read with stale data
        rd_stale <= host_wr_valid & (host_wr_addr == rd_addr);
      end else if (gap_cnt != '0) begin
        gap_cnt <= gap_cnt - 1'b1;
      end
      if (capture && dec_single_err && !rd_stale && !host_hit_pend) begin
        wr_req <= 1'b1;
      end else if (wr_grant) begin
        wr_req      <= 1'b0;
        fixed_count <= fixed_count + 1'b1;
      end else if (wr_req && host_wr_valid && (host_wr_addr == wr_addr)) begin
        wr_req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_grant) begin
      pend_addr <= rd_addr;
    end
    if (capture) begin
      wr_addr <= pend_addr;
      wr_word <= fix_word;
    end
  end

endmodule

// ==== src/ecc_merge_enc.sv ====
// Host write path: merges request bytes into the decoded old word,
// encodes check bits, applies the injection mask and issues the array write.
`timescale 1ns/10ps

module ecc_merge_enc
  import ecc_mem_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              req_valid,
  input  logic              req_write,
  input  logic [ADDR_W-1:0] req_addr,
  input  logic [DATA_W-1:0] req_wdata,
  input  logic [BE_W-1:0]   req_be,
  input  logic [CODE_W-1:0] req_inject,
  input  logic [DATA_W-1:0] dec_data,
  input  logic              dec_double_err,
  input  logic [DATA_W-1:0] rd_raw_data,
  output logic              wr_valid,
  output logic [ADDR_W-1:0] wr_addr,
  output ecc_word_u         wr_word
);

  // Request held while the old word is read
  logic              s1_valid;
  logic [ADDR_W-1:0] s1_addr;
  logic [DATA_W-1:0] s1_wdata;
  logic [BE_W-1:0]   s1_be;
  logic [CODE_W-1:0] s1_inject;

  logic [DATA_W-1:0] old_data;
  logic [DATA_W-1:0] merged;
  ecc_word_u         code;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
      wr_valid <= 1'b0;
    end else begin
      s1_valid <= req_valid & req_write;
      wr_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_valid && req_write) begin
      s1_addr   <= req_addr;
      s1_wdata  <= req_wdata;
      s1_be     <= req_be;
      s1_inject <= req_inject;
    end
  end

  // An uncorrectable old word is kept as read
  assign old_data = dec_double_err ? rd_raw_data : dec_data;

  always_comb begin
    for (int i = 0; i < BE_W; i++) begin
      merged[i*8 +: 8] = s1_be[i] ? s1_wdata[i*8 +: 8] : old_data[i*8 +: 8];
    end
    code.fld.data = merged;
    code.fld.ecc  = ecc_encode(merged);
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      wr_addr     <= s1_addr;
      wr_word.raw <= code.raw ^ s1_inject;
    end
  end

endmodule

// ==== src/ecc_dec.sv ====
// SECDED decoder on the array read data, plus the registered host response.
// The dec_ outputs are combinational and serve the merge path and the scrubber.
`timescale 1ns/10ps

module ecc_dec
  import ecc_mem_pkg::*;
(
  input  logic              clk,
  input  logic              reset,
  input  ecc_word_u         rd_word,
  input  logic              rd_owner_host,
  output logic [DATA_W-1:0] dec_data,
  output logic              dec_single_err,
  output logic              dec_double_err,
  output logic              rsp_valid,
  output logic [DATA_W-1:0] rsp_data,
  output logic              rsp_single_err,
  output logic              rsp_double_err
);

  logic [ECC_W-1:0]  syn_par;
  logic [ECC_W-2:0]  syndrome;
  logic              par_odd;
  logic [DATA_W-1:0] corrected;

  assign syn_par  = ecc_syndrome(rd_word);
  assign syndrome = syn_par[ECC_W-2:0];
  assign par_odd  = syn_par[ECC_W-1];

  // Flip the data bit at the syndrome position; check-bit hits leave data alone
  always_comb begin
    int unsigned pos;
    int unsigned d;
    corrected = rd_word.fld.data;
    d = 0;
    for (pos = 1; pos < CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (par_odd && (syndrome == pos[ECC_W-2:0])) begin
          corrected[d] = ~corrected[d];
        end
        d++;
      end
    end
  end

  assign dec_data       = corrected;
  assign dec_single_err = par_odd;
  assign dec_double_err = ~par_odd & (syndrome != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      rsp_valid <= 1'b0;
    end else begin
      rsp_valid <= rd_owner_host;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_owner_host) begin
      rsp_data       <= dec_data;
      rsp_single_err <= dec_single_err;
      rsp_double_err <= dec_double_err;
    end
  end

endmodule

// ==== src/mem_arbiter.sv ====
// Shares the array ports between the host path and the scrubber.
// Host has fixed priority on both ports.
`timescale 1ns/10ps

module mem_arbiter
  import ecc_mem_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              host_rd_req,
  input  logic [ADDR_W-1:0] host_rd_addr,
  input  logic              scrub_rd_req,
  input  logic [ADDR_W-1:0] scrub_rd_addr,
  input  logic              host_wr_req,
  input  logic [ADDR_W-1:0] host_wr_addr,
  input  ecc_word_u         host_wr_word,
  input  logic              scrub_wr_req,
  input  logic [ADDR_W-1:0] scrub_wr_addr,
  input  ecc_word_u         scrub_wr_word,
  output logic              rd_en,
  output logic [ADDR_W-1:0] rd_addr,
  output logic              rd_owner_host,
  output logic              scrub_rd_grant,
  output logic              wr_en,
  output logic [ADDR_W-1:0] wr_addr,
  output ecc_word_u         wr_word,
  output logic              scrub_wr_grant
);

  assign rd_en          = host_rd_req | scrub_rd_req;
  assign rd_addr        = host_rd_req ? host_rd_addr : scrub_rd_addr;
  assign scrub_rd_grant = scrub_rd_req & ~host_rd_req;

  assign wr_en          = host_wr_req | scrub_wr_req;
  assign wr_addr        = host_wr_req ? host_wr_addr : scrub_wr_addr;
  assign wr_word        = host_wr_req ? host_wr_word : scrub_wr_word;
  assign scrub_wr_grant = scrub_wr_req & ~host_wr_req;

  // Owner of the data the array returns next cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_owner_host <= 1'b0;
    end else begin
      rd_owner_host <= host_rd_req;
    end
  end

endmodule

// ==== src/ecc_mem_array.sv ====
// Code-word storage with one registered read port and one write port.
`timescale 1ns/10ps

module ecc_mem_array
  import ecc_mem_pkg::*;
#(
  parameter int ADDR_W = 4
) (
  input  logic              clk,
  input  logic              rd_en,
  input  logic [ADDR_W-1:0] rd_addr,
  input  logic              wr_en,
  input  logic [ADDR_W-1:0] wr_addr,
  input  ecc_word_u         wr_word,
  output ecc_word_u         rd_word
);

  ecc_word_u mem [2**ADDR_W];

  // Read returns the old contents when both ports hit the same address
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_word;
    end
    if (rd_en) begin
      rd_word <= mem[rd_addr];
    end
  end

endmodule

// ==== src/ecc_mem_pkg.sv ====
// Shared widths, the stored code-word union and the SECDED functions.
// Imported by the ECC memory RTL and its testbench.
package ecc_mem_pkg;

  localparam int DATA_W    = 32;
  localparam int ECC_W     = 7;
  localparam int CODE_W    = DATA_W + ECC_W;
  localparam int BE_W      = DATA_W / 8;
  localparam int FIX_CNT_W = 16;

  // One stored word, seen as a flat vector or as check bits over data
  typedef union packed {
    logic [CODE_W-1:0] raw;
    struct packed {
      logic [ECC_W-1:0]  ecc;
      logic [DATA_W-1:0] data;
    } fld;
  } ecc_word_u;

  // Hamming bits over data at non-power-of-two positions, then overall parity
  function automatic logic [ECC_W-1:0] ecc_encode(input logic [DATA_W-1:0] data);
    logic [ECC_W-1:0] chk;
    int unsigned pos;
    int unsigned d;
    int unsigned k;
    chk = '0;
    d = 0;
    for (pos = 1; pos < CODE_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        for (k = 0; k < ECC_W - 1; k++) begin
          if (pos[k]) chk[k] = chk[k] ^ data[d];
        end
        d++;
      end
    end
    chk[ECC_W-1] = ^{chk[ECC_W-2:0], data};
    return chk;
  endfunction

  // Top bit is the parity of the whole word, low bits are the syndrome
  function automatic logic [ECC_W-1:0] ecc_syndrome(input ecc_word_u word);
    logic [ECC_W-1:0] chk;
    chk = ecc_encode(word.fld.data);
    return {^word.raw, chk[ECC_W-2:0] ^ word.fld.ecc[ECC_W-2:0]};
  endfunction

endpackage
